// File: Bender.yml
package:
  name: sdmac_regs

sources:
  # Register and interrupt block RTL, in compile order
  - files:
      - hdl/sdmac_pkg.sv
      - hdl/reg_bus_if.sv
      - hdl/dma_fifo.sv
      - hdl/int_status.sv
      - hdl/reg_access.sv
      - hdl/sdmac_regs.sv
  # Bound assertions and testbench
  - target: test
    files:
      - bench/sdmac_regs_sva.sv
      - bench/sdmac_regs_tb.sv

// File: bench/sdmac_regs_sva.sv
//----------------------------------------------------------------------------
// Assertions bound into the register block top: reset values, ack
// timing, FIFO flag sanity and interrupt line gating
//----------------------------------------------------------------------------

`timescale 1ns/10ps

module sdmac_regs_sva (
  input logic CLK,
  input logic RESET_,
  input logic cpu_sel,
  input logic cpu_ack,
  input logic full,
  input logic empty,
  input logic intena,
  input logic int_req,
  input logic irq_
);

  // Failed assertions, read back by the testbench
  int unsigned fail_count = 0;

  // Idle outputs on the cycle after a reset edge
  a_reset: assert property (@(posedge CLK) !RESET_ |=> !cpu_ack && !intena && empty && irq_)
    else begin $error("outputs not at reset values"); fail_count++; end

  // Ack one cycle after the select, only then, and for one cycle
  a_ack_follow: assert property (@(posedge CLK) disable iff (!RESET_) cpu_sel |=> cpu_ack)
    else begin $error("select without acknowledge"); fail_count++; end
  a_ack_cause: assert property (@(posedge CLK) disable iff (!RESET_) cpu_ack |-> $past(cpu_sel))
    else begin $error("acknowledge without select"); fail_count++; end
  a_ack_single: assert property (@(posedge CLK) disable iff (!RESET_) cpu_ack |=> !cpu_ack)
    else begin $error("acknowledge longer than one cycle"); fail_count++; end

  a_flags: assert property (@(posedge CLK) disable iff (!RESET_) !(full && empty))
    else begin $error("FIFO full and empty together"); fail_count++; end

  // Interrupt line low exactly for an enabled request
  a_irq: assert property (@(posedge CLK) disable iff (!RESET_) irq_ == !(intena && int_req))
    else begin $error("irq_ does not follow intena and int_req"); fail_count++; end

endmodule

bind sdmac_regs sdmac_regs_sva u_sva (
  .CLK(CLK), .RESET_(RESET_), .cpu_sel(cpu_sel), .cpu_ack(cpu_ack), .full(full),
  .empty(empty), .intena(intena), .int_req(int_req), .irq_(irq_)
);

// File: bench/sdmac_regs_tb.sv
//----------------------------------------------------------------------------
// Testbench for the register and interrupt block. Drives host, DMA and
// interrupt inputs on the falling edge and checks each acknowledge
//----------------------------------------------------------------------------

`timescale 1ns/10ps

module sdmac_regs_tb;

  localparam int fifo_depth = 8;
  localparam int dw = sdmac_pkg::data_width;
  localparam int mix_ops = 200;
  // Reset, gating and end-of-process tests plus two FIFO fills and the mix
  localparam int test_cycles = 70 + 8 * fifo_depth + mix_ops;
  localparam int cycle_limit = 4 * test_cycles;

  logic CLK = 1'b0;
  logic RESET_;
  logic cpu_sel, cpu_wr, cpu_ack, dma_pop, int_req, dma_end, irq_;
  sdmac_pkg::reg_addr_e cpu_addr;
  logic [dw-1:0] cpu_wdata, cpu_rdata, dma_data, rd, rnd;
  logic [dw-1:0] words [fifo_depth];

  // Reference model state for FIFO contents, control bit, latch and snapshot
  logic [dw-1:0] m_q [$];
  logic m_intena, m_e_int;
  sdmac_pkg::istr_t m_snap, m_exp;
  // Pending acks as {kind, value}
  // Kind 0 is a write, 1 a data word, 2 an ISTR read
  logic [dw+1:0] exp_q [$];
  logic [dw+1:0] cmp;
  int occ;
  int errors = 0, errors_seen = 0, tests_run = 0, tests_failed = 0, cycles = 0;
  integer seed = 32'h97d20ca0;

  sdmac_regs #(.fifo_depth(fifo_depth)) dut (
    .CLK(CLK), .RESET_(RESET_), .cpu_sel(cpu_sel), .cpu_wr(cpu_wr),
    .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_rdata(cpu_rdata),
    .cpu_ack(cpu_ack), .dma_pop(dma_pop), .dma_data(dma_data),
    .int_req(int_req), .dma_end(dma_end), .irq_(irq_)
  );

  always #20 CLK = ~CLK;

  // ISTR as read back in the ack cycle
  // e_int follows the live latch
  function automatic sdmac_pkg::istr_t istr_expect(input logic req, input logic ena,
      input logic eint_old, input logic eint_new, input logic full, input logic empty);
    sdmac_pkg::istr_t s;
    s       = '0;
    s.int_f = req | eint_old;
    s.ints  = req;
    s.e_int = eint_new;
    s.int_p = req & ena;
    s.ff    = full;
    s.fe    = empty;
    return s;
  endfunction

  task automatic check_word(input string name, input logic [dw-1:0] got,
      input logic [dw-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_istr(input string name, input sdmac_pkg::istr_t got,
      input sdmac_pkg::istr_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%03h, expected 0x%03h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // One host access that returns in the ack cycle with the read data
  task automatic host_access(input logic wr, input sdmac_pkg::reg_addr_e addr,
      input logic [dw-1:0] data, output logic [dw-1:0] rdata);
    int waited;
    waited = 0;
    @(negedge CLK);
    cpu_sel   = 1'b1;
    cpu_wr    = wr;
    cpu_addr  = addr;
    cpu_wdata = data;
    @(negedge CLK);
    cpu_sel = 1'b0;
    while (!cpu_ack && waited < 4) begin
      @(negedge CLK);
      waited++;
    end
    if (!cpu_ack) begin
      $display("no acknowledge for the access to %s", addr.name());
      errors++;
    end
    rdata = cpu_rdata;
  endtask

  task automatic host_write(input sdmac_pkg::reg_addr_e addr, input logic [dw-1:0] data);
    logic [dw-1:0] unused;
    host_access(1'b1, addr, data, unused);
  endtask

  task automatic host_read(input sdmac_pkg::reg_addr_e addr, output logic [dw-1:0] data);
    host_access(1'b0, addr, '0, data);
  endtask

  // Head word must match before the pop edge
  task automatic pop_word(input logic [dw-1:0] exp);
    @(negedge CLK);
    check_word("dma_data", dma_data, exp);
    dma_pop = 1'b1;
    @(negedge CLK);
    dma_pop = 1'b0;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_seen) begin
      $display("test %-18s ok", name);
    end else begin
      tests_failed++;
      $display("test %-18s %0d errors", name, errors - errors_seen);
    end
    errors_seen = errors;
  endtask

  // Reference model stepped on every rising edge from the driven inputs
  always @(posedge CLK) begin
    if (!RESET_) begin
      m_q.delete();
      exp_q.delete();
      m_intena = 1'b0;
      m_e_int  = 1'b0;
      m_snap   = 9'h001;
    end else begin
      occ = m_q.size();
      if (cpu_sel && !cpu_wr) begin
        case (cpu_addr)
          sdmac_pkg::ADDR_CNTR: exp_q.push_back({2'd1, dw'(m_intena)});
          sdmac_pkg::ADDR_ISTR:
            m_snap = istr_expect(int_req, m_intena, m_e_int, 1'b0, occ == fifo_depth, occ == 0);
          sdmac_pkg::ADDR_CINT: exp_q.push_back({2'd1, {dw{1'b0}}});
          default:              exp_q.push_back({2'd1, dw'(occ)});
        endcase
      end
      // Pop on empty ignored, push on full dropped
      if (dma_pop && occ != 0) void'(m_q.pop_front());
      if (cpu_sel && cpu_wr) begin
        exp_q.push_back({2'd0, {dw{1'b0}}});
        if (cpu_addr == sdmac_pkg::ADDR_FIFO && occ != fifo_depth) m_q.push_back(cpu_wdata);
        if (cpu_addr == sdmac_pkg::ADDR_CNTR) m_intena = cpu_wdata[0];
        if (cpu_addr == sdmac_pkg::ADDR_CINT) begin
          m_snap.int_f = 1'b0;
          m_snap.ints  = 1'b0;
          m_snap.int_p = 1'b0;
          m_e_int      = 1'b0;
        end
      end
      // Set of the latch beats a clear in the same cycle
      if (dma_end) m_e_int = 1'b1;
      if (cpu_sel && !cpu_wr && cpu_addr == sdmac_pkg::ADDR_ISTR) begin
        m_exp       = m_snap;
        m_exp.e_int = m_e_int;
        exp_q.push_back({2'd2, dw'(m_exp)});
      end
    end
  end

  // Compare process takes one model entry per acknowledge
  always @(negedge CLK) begin
    if (RESET_ && cpu_ack) begin
      if (exp_q.size() == 0) begin
        $display("acknowledge seen with no access pending");
        errors++;
      end else begin
        cmp = exp_q.pop_front();
        if (cmp[dw+1:dw] == 2'd1) check_word("cpu_rdata", cpu_rdata, cmp[dw-1:0]);
        if (cmp[dw+1:dw] == 2'd2) begin
          check_istr("cpu_rdata", cpu_rdata[8:0], cmp[8:0]);
          check_word("cpu_rdata upper bits", cpu_rdata >> 9, '0);
        end
      end
    end else if (RESET_) begin
      // Read data stays at zero outside the ack cycle
      check_word("cpu_rdata", cpu_rdata, '0);
    end
  end

  // Run limit
  always @(posedge CLK) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    RESET_    = 1'b0;
    cpu_sel   = 1'b0;
    cpu_wr    = 1'b0;
    cpu_addr  = sdmac_pkg::ADDR_CNTR;
    cpu_wdata = '0;
    dma_pop   = 1'b0;
    int_req   = 1'b0;
    dma_end   = 1'b0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    RESET_ = 1'b1;

    check_bit("irq_", irq_, 1'b1);
    host_read(sdmac_pkg::ADDR_ISTR, rd);
    check_istr("istr", rd[8:0], 9'h001);
    host_read(sdmac_pkg::ADDR_FIFO, rd);
    check_word("count", rd, '0);
    end_test("reset state");

    // Fill, one dropped push, then drain in order
    for (int i = 0; i < fifo_depth; i++) begin
      words[i] = $random(seed);
      host_write(sdmac_pkg::ADDR_FIFO, words[i]);
    end
    host_read(sdmac_pkg::ADDR_ISTR, rd);
    check_istr("istr", rd[8:0], istr_expect(0, 0, 0, 0, 1, 0));
    host_write(sdmac_pkg::ADDR_FIFO, $random(seed));
    host_read(sdmac_pkg::ADDR_FIFO, rd);
    check_word("count", rd, fifo_depth);
    for (int i = 0; i < fifo_depth; i++) pop_word(words[i]);
    host_read(sdmac_pkg::ADDR_ISTR, rd);
    check_istr("istr", rd[8:0], istr_expect(0, 0, 0, 0, 0, 1));
    end_test("fifo order and flags");

    @(negedge CLK);
    int_req = 1'b1;
    host_read(sdmac_pkg::ADDR_ISTR, rd);
    check_istr("istr", rd[8:0], istr_expect(1, 0, 0, 0, 0, 1));
    check_bit("irq_", irq_, 1'b1);
    host_write(sdmac_pkg::ADDR_CNTR, 32'h1);
    check_bit("irq_", irq_, 1'b0);
    host_read(sdmac_pkg::ADDR_ISTR, rd);
    check_istr("istr", rd[8:0], istr_expect(1, 1, 0, 0, 0, 1));
    @(negedge CLK);
    int_req = 1'b0;
    end_test("interrupt gating");

    // Full FIFO so the clear can be seen to keep ff
    for (int i = 0; i < fifo_depth; i++) host_write(sdmac_pkg::ADDR_FIFO, $random(seed));
    @(negedge CLK);
    dma_end = 1'b1;
    @(negedge CLK);
    dma_end = 1'b0;
    host_read(sdmac_pkg::ADDR_ISTR, rd);
    check_istr("istr", rd[8:0], istr_expect(0, 1, 1, 1, 1, 0));
    // Request held for one snapshot so the clear has ints and int_p to drop
    @(negedge CLK);
    int_req = 1'b1;
    host_read(sdmac_pkg::ADDR_ISTR, rd);
    check_istr("istr", rd[8:0], istr_expect(1, 1, 1, 1, 1, 0));
    @(negedge CLK);
    int_req = 1'b0;
    host_write(sdmac_pkg::ADDR_CINT, '0);
    check_istr("istr", dut.istr, istr_expect(0, 1, 0, 0, 1, 0));
    end_test("end of process");

    // Selects never come back to back so every ack stays one cycle
    for (int i = 0; i < mix_ops; i++) begin
      @(negedge CLK);
      check_bit("irq_", irq_, !(m_intena && int_req));
      if (m_q.size() != 0) check_word("dma_data", dma_data, m_q[0]);
      rnd       = $random(seed);
      cpu_sel   = rnd[0] && !cpu_sel;
      cpu_wr    = rnd[1];
      cpu_addr  = sdmac_pkg::reg_addr_e'(rnd[3:2]);
      cpu_wdata = $random(seed);
      dma_pop   = (rnd[5:4] == 2'b00);
      if (rnd[7:6] == 2'b00) int_req = rnd[8];
      dma_end   = (rnd[11:9] == 3'b000);
    end
    @(negedge CLK);
    cpu_sel = 1'b0;
    dma_pop = 1'b0;
    dma_end = 1'b0;
    repeat (2) @(negedge CLK);
    if (exp_q.size() != 0) begin
      $display("%0d accesses were never acknowledged", exp_q.size());
      errors++;
    end
    end_test("random mix");

    if (dut.u_sva.fail_count != 0) begin
      $display("%0d assertion failures during the run", dut.u_sva.fail_count);
      errors++;
    end
    $display("summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/dma_fifo.sv
//----------------------------------------------------------------------------
// Transfer FIFO between host register writes and the DMA data path.
// Host pushes through ADDR_FIFO writes, DMA drains with dma_pop
//----------------------------------------------------------------------------

`timescale 1ns/10ps

module dma_fifo #(
  parameter int fifo_depth = 8
) (
  input  logic                               CLK,
  input  logic                               RESET_,
  input  logic                               dma_pop,
  reg_bus_if.slave                           bus,
  output logic [sdmac_pkg::data_width-1:0]   dma_data,
  output logic                               full,
  output logic                               empty,
  output logic [$clog2(fifo_depth):0]        count
);

  // Pointer width, depth must be a power of two
  localparam int ptr_w = $clog2(fifo_depth);
  // Occupancy value when every slot is used
  localparam logic [ptr_w:0] full_cnt = (ptr_w + 1)'(fifo_depth);

  // Storage, no reset on payload
  logic [sdmac_pkg::data_width-1:0] mem [fifo_depth];

  // Circular pointers, wrap on their own width
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;

  // Accepted push and pop for this cycle
  logic push;
  logic pop;

  // Push only on a host write to the FIFO address
  // Dropped when already full
  assign push = bus.wr && (bus.addr == sdmac_pkg::ADDR_FIFO) && !full;

  // Pop on an empty FIFO is ignored
  // so a push into an empty FIFO with dma_pop only pushes
  assign pop = dma_pop && !empty;

  // Flags come from the registered count
  // so they move one cycle after the push or pop edge
  assign full  = (count == full_cnt);
  assign empty = (count == '0);

  // Head word, shown without latency
  assign dma_data = mem[rd_ptr];

  // Write port
  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= bus.wdata;
    end
  end

  // Pointers
  always_ff @(posedge CLK) begin
    if (!RESET_) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy counter
  always_ff @(posedge CLK) begin
    if (!RESET_) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        // Both or neither, level unchanged
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hdl/int_status.sv
//----------------------------------------------------------------------------
// Interrupt status unit. Takes an ISTR snapshot on a host status read,
// keeps the end-of-process latch and drives the active-low interrupt line
//----------------------------------------------------------------------------

`timescale 1ns/10ps

module int_status (
  input  logic              CLK,
  input  logic              RESET_,
  input  logic              int_req,
  input  logic              dma_end,
  input  logic              intena,
  input  logic              full,
  input  logic              empty,
  reg_bus_if.slave          bus,
  output sdmac_pkg::istr_t  istr,
  output logic              irq_
);

  // Snapshot bits
  logic int_f;
  logic ints;
  logic int_p;
  logic ff;
  logic fe;
  // Sticky end of process
  logic e_int;

  // Decoded strobes
  logic capture;
  logic clear;

  // Enabled request, shared by irq_ and int_p
  logic int_en;

  assign capture = bus.rd && (bus.addr == sdmac_pkg::ADDR_ISTR);
  assign clear   = bus.wr && (bus.addr == sdmac_pkg::ADDR_CINT);
  assign int_en  = intena && int_req;

  // Interrupt line follows the gated request directly
  assign irq_ = ~int_en;

  // End-of-process latch
  // set wins over a clear in the same cycle
  always_ff @(posedge CLK) begin
    if (!RESET_) begin
      e_int <= 1'b0;
    end else if (dma_end) begin
      e_int <= 1'b1;
    end else if (clear) begin
      e_int <= 1'b0;
    end
  end

  // Interrupt bits of the snapshot
  // Clear and capture never coincide, wr and rd are exclusive
  always_ff @(posedge CLK) begin
    if (!RESET_) begin
      int_f <= 1'b0;
      ints  <= 1'b0;
      int_p <= 1'b0;
    end else if (clear) begin
      int_f <= 1'b0;
      ints  <= 1'b0;
      int_p <= 1'b0;
    end else if (capture) begin
      int_f <= int_req || e_int;
      ints  <= int_req;
      int_p <= int_en;
    end
  end

  // FIFO flags of the snapshot, only reset clears them
  always_ff @(posedge CLK) begin
    if (!RESET_) begin
      ff <= 1'b0;
      fe <= 1'b1;
    end else if (capture) begin
      ff <= full;
      fe <= empty;
    end
  end

  // Pack into the ISTR layout, spares tied low
  always_comb begin
    istr           = '0;
    istr.int_f     = int_f;
    istr.ints      = ints;
    istr.e_int     = e_int;
    istr.int_p     = int_p;
    istr.ff        = ff;
    istr.fe        = fe;
  end

endmodule

// File: hdl/reg_access.sv
//----------------------------------------------------------------------------
// Host register access. Decodes a select into read and write strobes,
// holds the control register and returns read data with a one-cycle ack
//----------------------------------------------------------------------------

`timescale 1ns/10ps

module reg_access #(
  parameter int fifo_depth = 8
) (
  input  logic                               CLK,
  input  logic                               RESET_,
  input  logic                               cpu_sel,
  input  logic                               cpu_wr,
  input  sdmac_pkg::reg_addr_e               cpu_addr,
  input  logic [sdmac_pkg::data_width-1:0]   cpu_wdata,
  input  logic [$clog2(fifo_depth):0]        count,
  input  sdmac_pkg::istr_t                   istr,
  output logic [sdmac_pkg::data_width-1:0]   cpu_rdata,
  output logic                               cpu_ack,
  output logic                               intena,
  reg_bus_if.master                          bus
);

  localparam int dw     = sdmac_pkg::data_width;
  localparam int istr_w = $bits(sdmac_pkg::istr_t);

  // Registered read data for control, clear and count
  logic [dw-1:0] rd_data_q;
  // Read of ISTR pending for the ack cycle
  logic          rd_istr_q;

  // Strobes last exactly as long as the select
  assign bus.wr    = cpu_sel && cpu_wr;
  assign bus.rd    = cpu_sel && !cpu_wr;
  assign bus.addr  = cpu_addr;
  assign bus.wdata = cpu_wdata;

  // Control register, only intena is implemented
  always_ff @(posedge CLK) begin
    if (!RESET_) begin
      intena <= 1'b0;
    end else if (bus.wr && (bus.addr == sdmac_pkg::ADDR_CNTR)) begin
      intena <= cpu_wdata[0];
    end
  end

  // Ack one cycle after the select
  always_ff @(posedge CLK) begin
    if (!RESET_) begin
      cpu_ack   <= 1'b0;
      rd_istr_q <= 1'b0;
    end else begin
      cpu_ack   <= cpu_sel;
      rd_istr_q <= bus.rd && (bus.addr == sdmac_pkg::ADDR_ISTR);
    end
  end

  // Read multiplexer, sampled on the strobe edge
  // Writes leave zero behind so the ack cycle returns 0
  always_ff @(posedge CLK) begin
    rd_data_q <= '0;
    if (bus.rd) begin
      case (bus.addr)
        sdmac_pkg::ADDR_CNTR: rd_data_q <= {{(dw-1){1'b0}}, intena};
        sdmac_pkg::ADDR_FIFO: rd_data_q <= dw'(count);
        // CINT reads 0, ISTR comes from the snapshot
        default:              rd_data_q <= '0;
      endcase
    end
  end

  // The ISTR snapshot is taken on the same edge as the strobe,
  // so the ack cycle reads it straight from the status unit
  always_comb begin
    if (!cpu_ack) begin
      cpu_rdata = '0;
    end else if (rd_istr_q) begin
      cpu_rdata = {{(dw-istr_w){1'b0}}, istr};
    end else begin
      cpu_rdata = rd_data_q;
    end
  end

endmodule

// File: hdl/reg_bus_if.sv
//----------------------------------------------------------------------------
// Decoded host access strobes, driven by the register access unit and
// observed by the transfer FIFO and the interrupt status unit
//----------------------------------------------------------------------------

`timescale 1ns/10ps

interface reg_bus_if;

  // Register address of the current access
  sdmac_pkg::reg_addr_e addr;
  // One-cycle write strobe
  logic wr;
  // One-cycle read strobe, never high together with wr
  logic rd;
  // Host write data, valid with wr
  logic [sdmac_pkg::data_width-1:0] wdata;

  // Decoder side
  modport master (
    output addr,
    output wr,
    output rd,
    output wdata
  );

  // Register blocks
  modport slave (
    input addr,
    input wr,
    input rd,
    input wdata
  );

endinterface

// File: hdl/sdmac_pkg.sv
//----------------------------------------------------------------------------
// Shared definitions for the SCSI DMA register block: data width, host
// register address map and the ISTR layout. Referred to by scoped name only
//----------------------------------------------------------------------------

package sdmac_pkg;

  // Host data path and FIFO word width
  localparam int data_width = 32;

  // Host register map, decoded from the 2-bit register address
  typedef enum logic [1:0] {
    // Control register, bit 0 is the interrupt enable
    ADDR_CNTR = 2'd0,
    // Interrupt status snapshot, captured on read
    ADDR_ISTR = 2'd1,
    // Write clears the interrupt bits, read returns 0
    ADDR_CINT = 2'd2,
    // Write pushes a word, read returns the occupancy
    ADDR_FIFO = 2'd3
  } reg_addr_e;

  // Interrupt status register, 9 bits, MSB first
  typedef struct packed {
    // Bit 8, unused
    logic       spare_8;
    // Bit 7, interrupt follow: raw request or end of process
    logic       int_f;
    // Bit 6, raw SCSI interrupt request
    logic       ints;
    // Bit 5, sticky end-of-process latch
    logic       e_int;
    // Bit 4, interrupt pending (enabled request)
    logic       int_p;
    // Bits 3 and 2, unused
    logic [1:0] spare_3_2;
    // Bit 1, FIFO full
    logic       ff;
    // Bit 0, FIFO empty
    logic       fe;
  } istr_t;

endpackage

// File: hdl/sdmac_regs.sv
//----------------------------------------------------------------------------
// Register and interrupt block top level. Connects host access decode,
// transfer FIFO and interrupt status unit to plain host and DMA ports
//----------------------------------------------------------------------------

`timescale 1ns/10ps

module sdmac_regs #(
  parameter int fifo_depth = 8
) (
  input  logic                               CLK,
  input  logic                               RESET_,
  // Host side
  input  logic                               cpu_sel,
  input  logic                               cpu_wr,
  input  sdmac_pkg::reg_addr_e               cpu_addr,
  input  logic [sdmac_pkg::data_width-1:0]   cpu_wdata,
  output logic [sdmac_pkg::data_width-1:0]   cpu_rdata,
  output logic                               cpu_ack,
  // DMA side
  input  logic                               dma_pop,
  output logic [sdmac_pkg::data_width-1:0]   dma_data,
  // Interrupt side
  input  logic                               int_req,
  input  logic                               dma_end,
  output logic                               irq_
);

  // Decoded host strobes
  reg_bus_if bus ();

  // Point-to-point status wires
  logic                        full;
  logic                        empty;
  logic [$clog2(fifo_depth):0] count;
  logic                        intena;
  sdmac_pkg::istr_t            istr;

  reg_access #(
    .fifo_depth (fifo_depth)
  ) u_access (
    .CLK       (CLK),
    .RESET_    (RESET_),
    .cpu_sel   (cpu_sel),
    .cpu_wr    (cpu_wr),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .count     (count),
    .istr      (istr),
    .cpu_rdata (cpu_rdata),
    .cpu_ack   (cpu_ack),
    .intena    (intena),
    .bus       (bus.master)
  );

  dma_fifo #(
    .fifo_depth (fifo_depth)
  ) u_fifo (
    .CLK      (CLK),
    .RESET_   (RESET_),
    .dma_pop  (dma_pop),
    .bus      (bus.slave),
    .dma_data (dma_data),
    .full     (full),
    .empty    (empty),
    .count    (count)
  );

  int_status u_int (
    .CLK     (CLK),
    .RESET_  (RESET_),
    .int_req (int_req),
    .dma_end (dma_end),
    .intena  (intena),
    .full    (full),
    .empty   (empty),
    .bus     (bus.slave),
    .istr    (istr),
    .irq_    (irq_)
  );

endmodule

// File: sources.f
hdl/sdmac_pkg.sv
hdl/reg_bus_if.sv
hdl/dma_fifo.sv
hdl/int_status.sv
hdl/reg_access.sv
hdl/sdmac_regs.sv
bench/sdmac_regs_sva.sv
bench/sdmac_regs_tb.sv
